// File: fetchStage.f
verilog/fetchPkg.sv
verilog/pcUnit.sv
verilog/instrMemory.sv
verilog/fetchControl.sv
verilog/fetchStage.sv
testbench/tbClock.sv
testbench/tbFetchStage.sv

// File: Makefile
# Verilator build, run and lint for the fetch stage testbench.
TOP = tbFetchStage
OBJ = obj_dir

.PHONY: all run lint clean

all: run

$(OBJ)/V$(TOP): fetchStage.f verilog/*.sv testbench/*.sv
	verilator --binary --timing --timescale 1ns/100ps -f fetchStage.f \
		--top-module $(TOP) -Mdir $(OBJ)

run: $(OBJ)/V$(TOP)
	./$(OBJ)/V$(TOP)

lint:
	verilator --lint-only --timing --timescale 1ns/100ps -f fetchStage.f \
		--top-module $(TOP)

clean:
	rm -rf $(OBJ)

// File: testbench/fetchStimulus.txt
# L addr data | R | C newPC createDump statusD statusX statusM statusW
#   instr incPC err branchInstF instrValid; status = regWrt wrtReg[2:0] branchInst
L 0000 4140
L 0002 DB80
L 0004 65C0
L 0006 2005
L 0008 8AE0
L 000A E620
L 0040 44A0
L 0042 4321
L 01FC 4120
L 01FE 5A5A
R
# sequential fetch
C 0000 0 00000 00000 00000 00000 4140 0002 0 0 1
C 0000 0 00000 00000 00000 00000 DB80 0004 0 0 1
C 0000 0 00000 00000 00000 00000 65C0 0006 0 1 1
C 0000 0 00000 00000 00000 00000 2005 0008 0 1 1
C 0000 0 00000 00000 00000 00000 8AE0 000A 0 0 1
C 0000 0 00000 00000 00000 00000 E620 000C 0 0 1
R
# rs hazard in each stage, then rt write on a non rt opcode
C 0000 0 10010 00000 00000 00000 0800 0002 0 0 0
C 0000 0 00000 10010 00000 00000 0800 0002 0 0 0
C 0000 0 00000 00000 10010 00000 0800 0002 0 0 0
C 0000 0 00000 00000 00000 10010 0800 0002 0 0 0
C 0000 0 10100 00000 00000 00000 4140 0002 0 0 1
# rt class opcode at pc 2
C 0000 0 00000 11000 00000 00000 0800 0004 0 0 0
C 0000 0 00000 00000 00000 10110 0800 0004 0 0 0
C 0000 0 00000 00000 11000 00000 0800 0004 0 0 0
C 0000 0 11000 00000 00000 00000 0800 0004 0 0 0
C 0000 0 00000 00000 00000 00000 DB80 0004 0 0 1
# branches in D and X stall, M and W redirect
C 0000 0 00001 00000 00000 00000 0800 0006 0 0 0
C 0000 0 00000 00001 00000 00000 0800 0006 0 0 0
C 0040 0 11010 00000 00001 00000 0800 0006 0 0 0
C 0000 0 00000 00000 00000 00000 44A0 0042 0 0 1
C 0004 0 00000 00000 00000 00001 4321 0044 0 0 1
C 0000 0 00000 00000 00000 00000 65C0 0006 0 1 1
# odd target, then wrap at FFFE
C 0041 0 00000 00000 00001 00000 2005 0008 0 1 1
C FFFC 0 00000 00000 00000 00001 44A0 0043 1 0 1
C 0000 0 00000 00000 00000 00000 4120 FFFE 0 0 1
C 0000 0 00000 00000 00000 00000 5A5A 0000 1 0 1
C 0000 0 00000 00000 00000 00000 4140 0002 0 0 1
# halt holds until reset
C 0000 1 00000 00000 00000 00000 DB80 0004 0 0 1
C 0000 0 00000 00000 00000 00000 0800 0004 0 0 0
C 0040 0 00000 00000 00001 00000 0800 0004 0 0 0
C 0000 0 00000 00000 00000 00000 0800 0004 0 0 0
R
C 0000 0 00000 00000 00000 00000 4140 0002 0 0 1
C 0000 0 00000 00000 00000 00000 DB80 0004 0 0 1
# overwrite while running, seen on the next read
L 0006 ABCD
C 0000 0 00000 00000 00000 00000 ABCD 0008 0 0 1

// File: testbench/tbFetchStage.sv
/*
   Testbench for the fetch stage.
   Replays load, reset and cycle rows from the stimulus file and checks the outputs.
*/
module tbFetchStage import fetchPkg::*; ();
   timeunit 1ns;
   timeprecision 100ps;

   localparam string stimFile = "testbench/fetchStimulus.txt";

   logic        clk;
   logic        arstN;
   word_t       newPC;
   logic        createDump;
   pipeStatus_t statusD;
   pipeStatus_t statusX;
   pipeStatus_t statusM;
   pipeStatus_t statusW;
   memLoad_t    load;
   word_t       instruction;
   word_t       incPC;
   logic        err;
   logic        branchInstF;
   logic        instrValid;

   int cycles = 0;
   int cycleLimit = 0;

   tbClock uClock (
      .clk (clk)
   );

   fetchStage #(
      .memWords (256)
   ) i_dut (
      .clk         (clk),
      .arstN       (arstN),
      .newPC       (newPC),
      .createDump  (createDump),
      .statusD     (statusD),
      .statusX     (statusX),
      .statusM     (statusM),
      .statusW     (statusW),
      .load        (load),
      .instruction (instruction),
      .incPC       (incPC),
      .err         (err),
      .branchInstF (branchInstF),
      .instrValid  (instrValid)
   );

   // limit is set at time zero, before the first edge.
   always @(posedge clk) begin
      cycles = cycles + 1;
      if (cycleLimit > 0 && cycles > cycleLimit) begin
         $display("timeout after %0d cycles, the stimulus rows did not finish", cycles);
         $display("TEST RESULT: FAIL");
         $fatal(1, "cycle limit reached");
      end
   end

   task automatic checkValue(input string name, input word_t actual, input word_t expected);
      if (actual !== expected) begin
         $display("ERR %0d ns %s is %h, expected %h", $time, name, actual, expected);
         $display("TEST RESULT: FAIL");
         $fatal(1, "output mismatch");
      end
   endtask

   function automatic int openStimulus();
      int fd;
      fd = $fopen(stimFile, "r");
      if (fd == 0) begin
         $display("cannot open the stimulus file %s", stimFile);
         $display("TEST RESULT: FAIL");
         $fatal(1, "stimulus file missing");
      end
      return fd;
   endfunction

   // data rows only, comments and blank lines do not count.
   function automatic int countRows();
      int    fd;
      int    rows;
      string line;
      fd = openStimulus();
      rows = 0;
      while ($fgets(line, fd) != 0) begin
         if (line.getc(0) == "L" || line.getc(0) == "R" || line.getc(0) == "C") begin
            rows = rows + 1;
         end
      end
      $fclose(fd);
      return rows;
   endfunction

   task automatic rejectRow(input string line);
      $display("malformed stimulus row: %s", line);
      $display("TEST RESULT: FAIL");
      $fatal(1, "bad stimulus row");
   endtask

   task automatic driveIdle();
      newPC      = '0;
      createDump = 1'b0;
      statusD    = '0;
      statusX    = '0;
      statusM    = '0;
      statusW    = '0;
      load       = '0;
   endtask

   task automatic applyReset();
      driveIdle();
      arstN = 1'b0;
      repeat (2) @(posedge clk);
      #10;
      arstN = 1'b1;
   endtask

   task automatic loadWord(input word_t addr, input word_t data);
      driveIdle();
      load = {1'b1, addr, data};
      @(posedge clk);
      #10;
      load = '0;
   endtask

   initial begin
      int          fd;
      int          got;
      byte         kind;
      string       line;
      logic [15:0] vAddr;
      logic [15:0] vData;
      logic [15:0] vNewPC;
      logic [15:0] expInstr;
      logic [15:0] expIncPC;
      logic        vCd;
      logic        expErr;
      logic        expBr;
      logic        expValid;
      logic [4:0]  vSd;
      logic [4:0]  vSx;
      logic [4:0]  vSm;
      logic [4:0]  vSw;

      arstN = 1'b0;
      driveIdle();
      cycleLimit = 2 * countRows() + 20;
      applyReset();
      fd = openStimulus();
      while ($fgets(line, fd) != 0) begin
         kind = line.getc(0);
         if (kind == "L") begin
            got = $sscanf(line, "L %h %h", vAddr, vData);
            if (got != 2) rejectRow(line);
            else loadWord(vAddr, vData);
         end else if (kind == "R") begin
            applyReset();
         end else if (kind == "C") begin
            got = $sscanf(line, "C %h %b %b %b %b %b %h %h %b %b %b", vNewPC, vCd,
                          vSd, vSx, vSm, vSw, expInstr, expIncPC, expErr, expBr, expValid);
            if (got != 11) begin
               rejectRow(line);
            end else begin
               newPC      = vNewPC;
               createDump = vCd;
               statusD    = vSd;
               statusX    = vSx;
               statusM    = vSm;
               statusW    = vSw;
               // sample late in the cycle, after the combinational paths settle.
               #80;
               checkValue("instruction", instruction, expInstr);
               checkValue("incPC", incPC, expIncPC);
               checkValue("err", 16'(err), 16'(expErr));
               checkValue("branchInstF", 16'(branchInstF), 16'(expBr));
               checkValue("instrValid", 16'(instrValid), 16'(expValid));
               @(posedge clk);
               #10;
            end
         end else if (kind != "#" && kind != 8'h0a && kind != 8'h0d) begin
            rejectRow(line);
         end
      end
      $fclose(fd);
      $display("TEST RESULT: PASS");
      $finish;
   end

endmodule

// File: testbench/tbClock.sv
/*
   Testbench clock source, 100 ns period.
*/
module tbClock (
   output logic clk
);
   timeunit 1ns;
   timeprecision 100ps;

   initial begin
      clk = 1'b0;
      forever begin
         #50 clk = ~clk;
      end
   end

endmodule

// File: verilog/fetchStage.sv
/*
   Instruction fetch stage of the 16-bit five-stage pipeline.
   Ties the PC unit, instruction memory and hazard/halt control together.
*/
module fetchStage import fetchPkg::*; #(
   parameter int unsigned memWords = 256
) (
   input  logic        clk,
   input  logic        arstN,
   input  word_t       newPC,
   input  logic        createDump,
   input  pipeStatus_t statusD,
   input  pipeStatus_t statusX,
   input  pipeStatus_t statusM,
   input  pipeStatus_t statusW,
   input  memLoad_t    load,
   output word_t       instruction,
   output word_t       incPC,
   output logic        err,
   output logic        branchInstF,
   output logic        instrValid
);

   word_t pc;
   word_t fetched;
   logic  pcWrEn;
   logic  redirect;

   pcUnit uPcUnit (
      .clk      (clk),
      .arstN    (arstN),
      .pcWrEn   (pcWrEn),
      .redirect (redirect),
      .newPC    (newPC),
      .pc       (pc),
      .incPC    (incPC),
      .err      (err)
   );

   instrMemory #(
      .memWords (memWords)
   ) uInstrMemory (
      .clk     (clk),
      .pc      (pc),
      .load    (load),
      .fetched (fetched)
   );

   fetchControl uFetchControl (
      .clk         (clk),
      .arstN       (arstN),
      .fetched     (fetched),
      .createDump  (createDump),
      .statusD     (statusD),
      .statusX     (statusX),
      .statusM     (statusM),
      .statusW     (statusW),
      .pcWrEn      (pcWrEn),
      .redirect    (redirect),
      .instruction (instruction),
      .branchInstF (branchInstF),
      .instrValid  (instrValid)
   );

endmodule

// File: verilog/fetchControl.sv
/*
   Fetch hazard and halt controller.
   Decides stall, redirect, PC write enable and NOP issue.
*/
module fetchControl import fetchPkg::*; (
   input  logic        clk,
   input  logic        arstN,
   input  word_t       fetched,
   input  logic        createDump,
   input  pipeStatus_t statusD,
   input  pipeStatus_t statusX,
   input  pipeStatus_t statusM,
   input  pipeStatus_t statusW,
   output logic        pcWrEn,
   output logic        redirect,
   output word_t       instruction,
   output logic        branchInstF,
   output logic        instrValid
);

   fetchState_t state;
   fetchState_t nextState;
   opcode_t     opcode;
   regIdx_t     rs;
   regIdx_t     rt;
   logic        readsRt;
   logic        isBranch;
   logic        isJump;
   logic        dataHazard;
   logic        stall;
   logic        halted;
   logic        issueNop;

   // true when a stage will overwrite one of our sources.
   function automatic logic writesSource(
      input pipeStatus_t st,
      input regIdx_t     srcS,
      input regIdx_t     srcT,
      input logic        useT
   );
      return st.regWrt && ((st.wrtReg == srcS) || (useT && (st.wrtReg == srcT)));
   endfunction

   // field decode of the fetched word.
   assign opcode = fetched[15:11];
   assign rs     = fetched[10:8];
   assign rt     = fetched[7:5];

   assign isBranch = (opcode[4:2] == branchPrefix);
   assign isJump   = (opcode[4:2] == jumpPrefix);

   assign readsRt = (opcode == opAluRr) || (opcode == opShiftRr) ||
                    (opcode[4:2] == setCondPrefix) ||
                    (opcode == opSt) || (opcode == opLd) || (opcode == opStu);

   assign dataHazard = writesSource(statusD, rs, rt, readsRt) ||
                       writesSource(statusX, rs, rt, readsRt) ||
                       writesSource(statusM, rs, rt, readsRt) ||
                       writesSource(statusW, rs, rt, readsRt);

   // control transfer still unresolved in D or X.
   assign stall = dataHazard || statusD.branchInst || statusX.branchInst;

   // resolved target arrives from M or W.
   assign redirect = statusM.branchInst || statusW.branchInst;

   assign halted   = (state == fsHalted);
   assign issueNop = halted || stall;

   // a redirect overrides the stall but never the halt.
   assign pcWrEn = !halted && !createDump && (!stall || redirect);

   // halt FSM, only reset leaves fsHalted.
   always_comb begin
      nextState = state;
      if (state == fsRun && createDump) begin
         nextState = fsHalted;
      end
   end

   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         state <= fsRun;
      end else begin
         state <= nextState;
      end
   end

   always_comb begin
      if (issueNop) begin
         instruction = nopInstr;
         instrValid  = 1'b0;
         branchInstF = 1'b0;
      end else begin
         instruction = fetched;
         instrValid  = 1'b1;
         branchInstF = isBranch || isJump;
      end
   end

endmodule

// File: verilog/instrMemory.sv
/*
   Instruction storage, word addressed.
   Asynchronous read at the PC, synchronous load port.
*/
module instrMemory import fetchPkg::*; #(
   parameter int unsigned memWords = 256
) (
   input  logic     clk,
   input  word_t    pc,
   input  memLoad_t load,
   output word_t    fetched
);

   localparam int idxW = (memWords > 1) ? $clog2(memWords) : 1;

   // contents stay undefined until loaded.
   word_t mem [memWords];

   logic [idxW-1:0] rdIdx;
   logic [idxW-1:0] wrIdx;

   // byte address to word index, folded onto the array depth.
   assign rdIdx = idxW'(pc[15:1] % memWords);
   assign wrIdx = idxW'(load.addr[15:1] % memWords);

   assign fetched = mem[rdIdx];

   // a load shows up in the next cycle's read.
   always_ff @(posedge clk) begin
      if (load.en) begin
         mem[wrIdx] <= load.data;
      end
   end

endmodule

// File: verilog/pcUnit.sv
/*
   PC register with +2 incrementer and redirect select.
   Flags PC wrap and misaligned PC on err.
*/
module pcUnit import fetchPkg::*; (
   input  logic  clk,
   input  logic  arstN,
   input  logic  pcWrEn,
   input  logic  redirect,
   input  word_t newPC,
   output word_t pc,
   output word_t incPC,
   output logic  err
);

   word_t nextPc;
   logic  incCarry;
   logic  misaligned;

   // carry out of the add marks a wrap past 16'hFFFE.
   assign {incCarry, incPC} = {1'b0, pc} + 17'd2;

   // only an odd newPC can leave the low bit set.
   assign misaligned = pc[0];

   assign err = incCarry || misaligned;

   assign nextPc = redirect ? newPC : incPC;

   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         pc <= '0;
      end else if (pcWrEn) begin
         pc <= nextPc;
      end
   end

endmodule

// File: verilog/fetchPkg.sv
/*
   Fetch stage shared definitions: word and register types,
   downstream stage status, load port, FSM states and opcode classes.
*/
package fetchPkg;

   // instruction or address word.
   typedef logic [15:0] word_t;
   typedef logic [2:0]  regIdx_t;

   // major opcode, instruction bits 15 to 11.
   typedef logic [4:0]  opcode_t;

   // what one downstream stage tells fetch.
   typedef struct packed {
      logic    regWrt;
      regIdx_t wrtReg;
      logic    branchInst;
   } pipeStatus_t;

   // instruction memory load port, addr is a byte address.
   typedef struct packed {
      logic  en;
      word_t addr;
      word_t data;
   } memLoad_t;

   typedef enum logic {
      fsRun,
      fsHalted
   } fetchState_t;

   localparam word_t nopInstr = 16'h0800;

   // class prefixes, compared against opcode bits 4 to 2.
   localparam logic [2:0] branchPrefix  = 3'b011;
   localparam logic [2:0] jumpPrefix    = 3'b001;
   localparam logic [2:0] setCondPrefix = 3'b111;

   // single opcodes whose rt field is a source.
   localparam opcode_t opAluRr   = 5'b11011;
   localparam opcode_t opShiftRr = 5'b11010;
   localparam opcode_t opSt      = 5'b10000;
   localparam opcode_t opLd      = 5'b10001;
   localparam opcode_t opStu     = 5'b10011;

endpackage
